// File: be_scheduler.f
verilog/sched_pkg.sv
verilog/int_regfile.sv
verilog/issue_buffer.sv
verilog/dispatch_arbiter.sv
verilog/stride_detector.sv
verilog/prefetch_generator.sv
verilog/be_scheduler.sv
tb/be_scheduler_props.sv
tb/be_scheduler_tb.sv

// File: tb/be_scheduler_props.sv
// concurrent checks on dispatch priority and reset, bound into be_scheduler
// failures are counted in prop_errors so the testbench can read them
`timescale 1ns/10ps

module be_scheduler_props
  (input logic                       clk_i
   , input logic                     reset_i
   , input sched_pkg::dispatch_pkt_s dispatch_pkt_i
   , input logic                     late_wb_yumi_i
   , input logic                     issue_v_i
   , input logic                     hazard_v_i
   , input logic                     late_wb_v_i
   , input logic                     resume_i
   , input logic                     irq_pending_i
   , input logic                     fe_ready_i
   , input logic                     suppress_iss_i
   );

  import sched_pkg::*;

  int unsigned prop_errors = 0;

  assert property (@(posedge clk_i) disable iff (reset_i)
    late_wb_yumi_i == (dispatch_pkt_i.kind == e_late_wb))
  else
  begin
    $error("late_wb_yumi_o does not match a late writeback dispatch");
    prop_errors++;
  end

  // prefetch only in slots no other source wants
  assert property (@(posedge clk_i) disable iff (reset_i)
    (dispatch_pkt_i.kind == e_prefetch) |->
      !(issue_v_i && !hazard_v_i) && !late_wb_v_i && !resume_i && !irq_pending_i)
  else
  begin
    $error("prefetch dispatched while another source was pending");
    prop_errors++;
  end

  assert property (@(posedge clk_i) reset_i |=> !dispatch_pkt_i.v)
  else
  begin
    $error("dispatch valid during reset or the cycle after it");
    prop_errors++;
  end

  assert property (@(posedge clk_i) suppress_iss_i |-> !fe_ready_i)
  else
  begin
    $error("fe_ready_o high while the issue buffer is suppressed");
    prop_errors++;
  end

endmodule

bind be_scheduler be_scheduler_props props_i
  (.clk_i(clk_i), .reset_i(reset_i), .dispatch_pkt_i(dispatch_pkt_o)
   ,.late_wb_yumi_i(late_wb_yumi_o), .issue_v_i(issue_v), .hazard_v_i(hazard_v_i)
   ,.late_wb_v_i(late_wb_v_i), .resume_i(resume_i), .irq_pending_i(irq_pending_i)
   ,.fe_ready_i(fe_ready_o), .suppress_iss_i(suppress_iss_i)
   );

// File: tb/be_scheduler_tb.sv
// directed test of the back-end scheduler, outputs sampled on the falling edge
// relies on the bound property module for priority and reset checks
`timescale 1ns/10ps

module be_scheduler_tb;

  import sched_pkg::*;

  logic          clk = 1'b0;
  logic          reset;
  fe_pkt_s       fe_pkt;
  logic          fe_v, fe_ready, clear_iss, suppress_iss;
  logic          hazard_v, resume, irq_pending;
  vaddr_t        expected_npc;
  wb_pkt_s       iwb_pkt, late_wb_pkt;
  logic          late_wb_v, late_wb_force, late_wb_yumi;
  dispatch_pkt_s dispatch_pkt;

  integer        seed;
  int            errors, checks, pf_count;
  dword_t        x5_data, x6_data, a_base;
  dispatch_pkt_s pkt;

  always #10 clk = ~clk;

  be_scheduler dut_i
   (.clk_i(clk), .reset_i(reset), .fe_pkt_i(fe_pkt), .fe_v_i(fe_v), .fe_ready_o(fe_ready)
    ,.clear_iss_i(clear_iss), .suppress_iss_i(suppress_iss), .hazard_v_i(hazard_v)
    ,.resume_i(resume), .irq_pending_i(irq_pending), .expected_npc_i(expected_npc)
    ,.iwb_pkt_i(iwb_pkt), .late_wb_pkt_i(late_wb_pkt), .late_wb_v_i(late_wb_v)
    ,.late_wb_force_i(late_wb_force), .late_wb_yumi_o(late_wb_yumi)
    ,.dispatch_pkt_o(dispatch_pkt)
    );

  function automatic instr_t encode_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [6:0] opcode);
    return {7'b0, rs2, rs1, 3'b011, rd, opcode};
  endfunction

  function automatic fe_pkt_s instr_pkt(input vaddr_t pc, input instr_t instr,
                                        input dword_t imm, input logic load);
    fe_pkt_s p;
    p         = '0;
    p.pc      = pc;
    p.instr   = instr;
    p.rs1_r_v = 1'b1;
    p.rs2_r_v = 1'b1;
    p.imm     = imm;
    p.load_v  = load;
    return p;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input dword_t data);
    @(posedge clk);
    iwb_pkt <= '{w_v: 1'b1, rd_addr: addr, data: data};
    @(posedge clk);
    iwb_pkt <= '0;
  endtask

  // holds valid until the buffer is ready, returns on the accepting edge
  task automatic send_pkt(input fe_pkt_s p);
    int n;
    n = 0;
    @(posedge clk);
    fe_pkt <= p;
    fe_v   <= 1'b1;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!fe_ready && n < 20);
    if (!fe_ready)
    begin
      $display("front end packet at pc %0h was never accepted", p.pc);
      errors++;
    end
    @(posedge clk);
    fe_v <= 1'b0;
  endtask

  task automatic wait_dispatch(input string name, output dispatch_pkt_s p);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    p    = '0;
    while (!seen && n < 30)
    begin
      @(negedge clk);
      n++;
      if (dispatch_pkt.v)
      begin
        seen = 1'b1;
        p    = dispatch_pkt;
      end
    end
    if (!seen)
    begin
      $display("%s: no dispatch seen before the timeout", name);
      errors++;
    end
  endtask

  task automatic expect_no_dispatch(input string name, input int cycles);
    int n;
    for (n = 0; n < cycles; n++)
    begin
      @(negedge clk);
      checks++;
      if (dispatch_pkt.v)
      begin
        $display("%s: unexpected dispatch of kind %s", name, dispatch_pkt.kind.name());
        errors++;
        break;
      end
    end
  endtask

  initial
  begin
    seed = 55;
    errors = 0;
    checks = 0;
    reset = 1'b1;
    fe_pkt = '0;
    fe_v = 1'b0;
    clear_iss = 1'b0;
    suppress_iss = 1'b0;
    hazard_v = 1'b0;
    resume = 1'b0;
    irq_pending = 1'b0;
    expected_npc = '0;
    iwb_pkt = '0;
    late_wb_pkt = '0;
    late_wb_v = 1'b0;
    late_wb_force = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // operand read
    x5_data = {$random(seed), $random(seed)};
    x6_data = {$random(seed), $random(seed)};
    write_reg(5, x5_data);
    write_reg(6, x6_data);
    send_pkt(instr_pkt(39'h1000, encode_instr(1, 5, 6, 7'b0110011), '0, 1'b0));
    wait_dispatch("operand read", pkt);
    check_value("operand kind", e_instr, pkt.kind);
    check_value("operand rs1", x5_data, pkt.rs1);
    check_value("operand rs2", x6_data, pkt.rs2);
    send_pkt(instr_pkt(39'h1004, encode_instr(2, 0, 6, 7'b0110011), '0, 1'b0));
    wait_dispatch("x0 read", pkt);
    check_value("x0 rs1", '0, pkt.rs1);

    // late writeback deferred, then forced
    @(posedge clk);
    hazard_v <= 1'b1;
    send_pkt(instr_pkt(39'h1008, encode_instr(3, 5, 6, 7'b0110011), '0, 1'b0));
    @(posedge clk);
    hazard_v    <= 1'b0;
    late_wb_v   <= 1'b1;
    late_wb_pkt <= '{w_v: 1'b1, rd_addr: 5'd7, data: x6_data};
    wait_dispatch("deferred wb first", pkt);
    check_value("deferred wb first kind", e_instr, pkt.kind);
    wait_dispatch("deferred wb second", pkt);
    check_value("deferred wb second kind", e_late_wb, pkt.kind);
    check_value("late wb rs2", x6_data, pkt.rs2);
    check_value("late wb rd", 7, pkt.rd_addr);
    @(posedge clk);
    late_wb_v <= 1'b0;
    hazard_v  <= 1'b1;
    send_pkt(instr_pkt(39'h100c, encode_instr(3, 5, 6, 7'b0110011), '0, 1'b0));
    @(posedge clk);
    hazard_v      <= 1'b0;
    late_wb_v     <= 1'b1;
    late_wb_force <= 1'b1;
    wait_dispatch("forced wb first", pkt);
    check_value("forced wb first kind", e_late_wb, pkt.kind);
    check_value("forced wb yumi", 1, late_wb_yumi);
    @(posedge clk);
    late_wb_v     <= 1'b0;
    late_wb_force <= 1'b0;
    wait_dispatch("forced wb second", pkt);
    check_value("forced wb second kind", e_instr, pkt.kind);

    // resume and interrupt held off by the hazard
    @(posedge clk);
    hazard_v     <= 1'b1;
    resume       <= 1'b1;
    irq_pending  <= 1'b1;
    expected_npc <= 39'h2340;
    send_pkt(instr_pkt(39'h1010, encode_instr(4, 5, 6, 7'b0110011), '0, 1'b0));
    expect_no_dispatch("hazard hold", 5);
    @(posedge clk);
    hazard_v <= 1'b0;
    wait_dispatch("resume", pkt);
    check_value("resume kind", e_resume, pkt.kind);
    check_value("resume pc", 39'h2340, pkt.pc);
    check_value("resume flag", 1, pkt.exception.resume);
    @(posedge clk);
    resume <= 1'b0;
    wait_dispatch("interrupt", pkt);
    check_value("interrupt kind", e_interrupt, pkt.kind);
    check_value("interrupt pc", 39'h2340, pkt.pc);
    @(posedge clk);
    irq_pending <= 1'b0;
    wait_dispatch("after interrupt", pkt);
    check_value("after interrupt kind", e_instr, pkt.kind);

    // front-end exception
    pkt = '0;
    send_pkt('{pc: 39'h3000, exc_v: 1'b1, illegal_instr: 1'b1, default: '0});
    wait_dispatch("fe exception", pkt);
    check_value("fe exception kind", e_fe_exc, pkt.kind);
    check_value("fe exception illegal", 1, pkt.exception.illegal_instr);
    check_value("fe exception rs1", 39'h3000, pkt.rs1);

    // three loads with a 16 byte stride
    a_base = 64'h8000_1000;
    write_reg(10, a_base);
    for (int k = 0; k < 3; k++)
    begin
      send_pkt(instr_pkt(39'h4000, encode_instr(11, 10, 0, 7'b0000011), dword_t'(k * 16), 1'b1));
      wait_dispatch("stride load", pkt);
      check_value("stride load kind", e_instr, pkt.kind);
    end
    pf_count = 0;
    for (int n = 0; n < 20; n++)
    begin
      @(negedge clk);
      if (dispatch_pkt.v && dispatch_pkt.kind == e_prefetch)
      begin
        check_value($sformatf("prefetch %0d addr", pf_count),
                    a_base + dword_t'((3 + pf_count) * 16), dispatch_pkt.rs1);
        pf_count++;
      end
    end
    check_value("prefetch count", 4, pf_count);

    // suppress, then clear of a held packet
    @(posedge clk);
    suppress_iss <= 1'b1;
    fe_pkt       <= instr_pkt(39'h5000, encode_instr(1, 5, 6, 7'b0110011), '0, 1'b0);
    fe_v         <= 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      check_value("suppress ready", 0, fe_ready);
    end
    @(posedge clk);
    suppress_iss <= 1'b0;
    fe_v         <= 1'b0;
    expect_no_dispatch("suppress", 5);
    @(posedge clk);
    hazard_v <= 1'b1;
    send_pkt(instr_pkt(39'h5004, encode_instr(1, 5, 6, 7'b0110011), '0, 1'b0));
    @(posedge clk);
    clear_iss <= 1'b1;
    @(posedge clk);
    clear_iss <= 1'b0;
    hazard_v  <= 1'b0;
    expect_no_dispatch("clear", 20);

    $display("checks %0d, errors %0d, assertion errors %0d",
             checks, errors, dut_i.props_i.prop_errors);
    if (errors == 0 && dut_i.props_i.prop_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: verilog/be_scheduler.sv
// back-end issue scheduler, front-end queue in, one dispatch packet per cycle out
// register operands come from the integer file only, no bypass from writeback
`timescale 1ns/10ps

module be_scheduler
  (input logic                        clk_i
   , input logic                      reset_i

   , input sched_pkg::fe_pkt_s        fe_pkt_i
   , input logic                      fe_v_i
   , output logic                     fe_ready_o

   , input logic                      clear_iss_i
   , input logic                      suppress_iss_i
   , input logic                      hazard_v_i
   , input logic                      resume_i
   , input logic                      irq_pending_i
   , input sched_pkg::vaddr_t         expected_npc_i

   , input sched_pkg::wb_pkt_s        iwb_pkt_i
   , input sched_pkg::wb_pkt_s        late_wb_pkt_i
   , input logic                      late_wb_v_i
   , input logic                      late_wb_force_i
   , output logic                     late_wb_yumi_o

   , output sched_pkg::dispatch_pkt_s dispatch_pkt_o
   );

  import sched_pkg::*;

  fe_pkt_s       issue_pkt;
  logic          issue_v, issue_deq;
  dword_t        rs1_data, rs2_data;
  logic          pf_v, pf_yumi, pf_req_v;
  vaddr_t        pf_addr, eff_addr;
  prefetch_req_s pf_req;
  logic          stride_load_v;

  issue_buffer issue_buf
   (.clk_i(clk_i), .reset_i(reset_i)
    ,.fe_pkt_i(fe_pkt_i), .fe_v_i(fe_v_i), .fe_ready_o(fe_ready_o)
    ,.clear_i(clear_iss_i), .suppress_i(suppress_iss_i), .deq_i(issue_deq)
    ,.issue_pkt_o(issue_pkt), .issue_v_o(issue_v)
    );

  // rs1 and rs2 fields of the instruction word
  int_regfile int_rf
   (.clk_i(clk_i), .reset_i(reset_i), .wb_i(iwb_pkt_i)
    ,.rs1_addr_i(issue_pkt.instr[19:15]), .rs2_addr_i(issue_pkt.instr[24:20])
    ,.rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

  dispatch_arbiter arbiter
   (.issue_pkt_i(issue_pkt), .issue_v_i(issue_v)
    ,.rs1_data_i(rs1_data), .rs2_data_i(rs2_data)
    ,.hazard_v_i(hazard_v_i), .resume_i(resume_i), .irq_pending_i(irq_pending_i)
    ,.expected_npc_i(expected_npc_i)
    ,.late_wb_i(late_wb_pkt_i), .late_wb_v_i(late_wb_v_i), .late_wb_force_i(late_wb_force_i)
    ,.late_wb_yumi_o(late_wb_yumi_o), .issue_deq_o(issue_deq)
    ,.pf_v_i(pf_v), .pf_addr_i(pf_addr), .pf_yumi_o(pf_yumi)
    ,.dispatch_pkt_o(dispatch_pkt_o)
    );

  // load address from the dispatched operand and immediate
  assign stride_load_v = dispatch_pkt_o.v & (dispatch_pkt_o.kind == e_instr) & issue_pkt.load_v;
  assign eff_addr      = vaddr_t'(dispatch_pkt_o.rs1 + dispatch_pkt_o.imm);

  stride_detector stride_det
   (.clk_i(clk_i), .reset_i(reset_i)
    ,.load_v_i(stride_load_v), .pc_i(dispatch_pkt_o.pc), .eff_addr_i(eff_addr)
    ,.pf_req_v_o(pf_req_v), .pf_req_o(pf_req)
    );

  prefetch_generator pf_gen
   (.clk_i(clk_i), .reset_i(reset_i)
    ,.pf_req_v_i(pf_req_v), .pf_req_i(pf_req)
    ,.pf_yumi_i(pf_yumi), .pf_v_o(pf_v), .pf_addr_o(pf_addr)
    );

endmodule

// File: verilog/dispatch_arbiter.sv
// fixed-priority dispatch: late writeback, resume, interrupt, front end, prefetch
// purely combinational, the hazard blocks everything but late writeback and prefetch
`timescale 1ns/10ps

module dispatch_arbiter
  (input sched_pkg::fe_pkt_s        issue_pkt_i
   , input logic                    issue_v_i
   , input sched_pkg::dword_t       rs1_data_i
   , input sched_pkg::dword_t       rs2_data_i

   , input logic                    hazard_v_i
   , input logic                    resume_i
   , input logic                    irq_pending_i
   , input sched_pkg::vaddr_t       expected_npc_i

   , input sched_pkg::wb_pkt_s      late_wb_i
   , input logic                    late_wb_v_i
   , input logic                    late_wb_force_i
   , output logic                   late_wb_yumi_o
   , output logic                   issue_deq_o

   , input logic                    pf_v_i
   , input sched_pkg::vaddr_t       pf_addr_i
   , output logic                   pf_yumi_o

   , output sched_pkg::dispatch_pkt_s dispatch_pkt_o
   );

  import sched_pkg::*;

  logic issue_queued, wb_v, resume_v, irq_v, be_v;
  logic fe_exc_v, fe_instr_v, pf_sel;
  dispatch_kind_e kind;

  assign issue_queued = issue_v_i & ~hazard_v_i;

  // a deferred late writeback still holds off resume and interrupt
  assign wb_v     = late_wb_v_i & (late_wb_force_i | ~issue_queued);
  assign resume_v = ~late_wb_v_i & ~hazard_v_i & resume_i;
  assign irq_v    = ~late_wb_v_i & ~hazard_v_i & ~resume_i & irq_pending_i;
  assign be_v     = wb_v | resume_v | irq_v;

  assign fe_exc_v   = ~be_v & issue_queued & issue_pkt_i.exc_v;
  assign fe_instr_v = ~be_v & issue_queued & ~issue_pkt_i.exc_v;

  // prefetch only fills a slot no other source could want
  assign pf_sel = pf_v_i & ~issue_queued & ~late_wb_v_i & ~resume_i & ~irq_pending_i;

  always_comb
  begin
    if (wb_v)            kind = e_late_wb;
    else if (resume_v)   kind = e_resume;
    else if (irq_v)      kind = e_interrupt;
    else if (fe_exc_v)   kind = e_fe_exc;
    else if (fe_instr_v) kind = e_instr;
    else if (pf_sel)     kind = e_prefetch;
    else                 kind = e_none;
  end

  always_comb
  begin
    dispatch_pkt_o      = '0;
    dispatch_pkt_o.v    = (kind != e_none);
    dispatch_pkt_o.kind = kind;
    case (kind)
      e_instr:
      begin
        dispatch_pkt_o.pc               = issue_pkt_i.pc;
        dispatch_pkt_o.instr            = issue_pkt_i.instr;
        dispatch_pkt_o.rs1              = issue_pkt_i.rs1_r_v ? rs1_data_i : '0;
        dispatch_pkt_o.rs2              = issue_pkt_i.rs2_r_v ? rs2_data_i : '0;
        dispatch_pkt_o.imm              = issue_pkt_i.imm;
        // rd field of the instruction word
        dispatch_pkt_o.rd_addr          = issue_pkt_i.instr[11:7];
        dispatch_pkt_o.exception.ecall  = issue_pkt_i.ecall;
        dispatch_pkt_o.exception.ebreak = issue_pkt_i.ebreak;
      end
      e_fe_exc:
      begin
        dispatch_pkt_o.pc    = issue_pkt_i.pc;
        dispatch_pkt_o.instr = issue_pkt_i.instr;
        dispatch_pkt_o.rs1   = dword_t'(issue_pkt_i.pc);
        dispatch_pkt_o.exception.instr_page_fault = issue_pkt_i.instr_page_fault;
        dispatch_pkt_o.exception.illegal_instr    = issue_pkt_i.illegal_instr;
      end
      e_late_wb:
      begin
        dispatch_pkt_o.rs2     = late_wb_i.data;
        // x0 target means no register write
        dispatch_pkt_o.rd_addr = late_wb_i.w_v ? late_wb_i.rd_addr : '0;
      end
      e_resume:
      begin
        dispatch_pkt_o.pc               = expected_npc_i;
        dispatch_pkt_o.exception.resume = 1'b1;
      end
      e_interrupt:
      begin
        dispatch_pkt_o.pc                  = expected_npc_i;
        dispatch_pkt_o.exception.interrupt = 1'b1;
      end
      e_prefetch:
      begin
        dispatch_pkt_o.rs1 = dword_t'(pf_addr_i);
      end
      default:
      begin
      end
    endcase
  end

  assign late_wb_yumi_o = wb_v;
  assign issue_deq_o    = fe_exc_v | fe_instr_v;
  assign pf_yumi_o      = (kind == e_prefetch);

endmodule

// File: verilog/int_regfile.sv
// integer register file, x0 reads as zero and ignores writes
// reads are combinational and see the old value during a same-cycle write
`timescale 1ns/10ps

module int_regfile
  (input logic                  clk_i
   , input logic                reset_i

   , input sched_pkg::wb_pkt_s  wb_i

   , input sched_pkg::reg_addr_t rs1_addr_i
   , input sched_pkg::reg_addr_t rs2_addr_i
   , output sched_pkg::dword_t  rs1_data_o
   , output sched_pkg::dword_t  rs2_data_o
   );

  import sched_pkg::*;

  // no storage behind x0
  dword_t regs_r [num_regs_lp-1:1];
  logic   write_v;

  // writes are held off while in reset
  assign write_v = wb_i.w_v & (wb_i.rd_addr != '0) & ~reset_i;

  always_ff @(posedge clk_i)
  begin
    if (write_v)
    begin
      regs_r[wb_i.rd_addr] <= wb_i.data;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_r[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_r[rs2_addr_i];

endmodule

// File: verilog/issue_buffer.sv
// one-entry buffer between the front-end queue and dispatch
// a clear drops the entry and also any packet accepted in the same cycle
`timescale 1ns/10ps

module issue_buffer
  (input logic                 clk_i
   , input logic               reset_i

   , input sched_pkg::fe_pkt_s fe_pkt_i
   , input logic               fe_v_i
   , output logic              fe_ready_o

   , input logic               clear_i
   , input logic               suppress_i
   , input logic               deq_i

   , output sched_pkg::fe_pkt_s issue_pkt_o
   , output logic              issue_v_o
   );

  import sched_pkg::*;

  fe_pkt_s pkt_r;
  logic    v_r;
  logic    accept;

  // refill allowed in the cycle the held packet leaves
  assign fe_ready_o = ~suppress_i & (~v_r | deq_i);
  assign accept     = fe_v_i & fe_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i | clear_i)
    begin
      v_r <= 1'b0;
    end
    else if (accept)
    begin
      v_r <= 1'b1;
    end
    else if (deq_i)
    begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      pkt_r <= fe_pkt_i;
    end
  end

  assign issue_pkt_o = pkt_r;
  assign issue_v_o   = v_r;

endmodule

// File: verilog/prefetch_generator.sv
// emits prefetch_depth_lp addresses past the base of a confirmed stride
// requests arriving while a burst is in progress are dropped
`timescale 1ns/10ps

module prefetch_generator
  (input logic                       clk_i
   , input logic                     reset_i

   , input logic                     pf_req_v_i
   , input sched_pkg::prefetch_req_s pf_req_i

   , input logic                     pf_yumi_i
   , output logic                    pf_v_o
   , output sched_pkg::vaddr_t       pf_addr_o
   );

  import sched_pkg::*;

  gen_state_e state_r;
  vaddr_t     addr_r;
  stride_t    stride_r;
  logic [pf_count_width_lp-1:0] count_r;
  vaddr_t     req_stride_ext, stride_ext;

  // sign extended strides
  assign req_stride_ext = {{(vaddr_width_lp-stride_width_lp){pf_req_i.stride[stride_width_lp-1]}},
                           pf_req_i.stride};
  assign stride_ext     = {{(vaddr_width_lp-stride_width_lp){stride_r[stride_width_lp-1]}},
                           stride_r};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
      count_r <= '0;
    end
    else if ((state_r == e_idle) & pf_req_v_i)
    begin
      state_r  <= e_emit;
      count_r  <= prefetch_depth_lp[pf_count_width_lp-1:0];
      addr_r   <= pf_req_i.base + req_stride_ext;
      stride_r <= pf_req_i.stride;
    end
    else if ((state_r == e_emit) & pf_yumi_i)
    begin
      count_r <= count_r - 1'b1;
      addr_r  <= addr_r + stride_ext;
      if (count_r == 1)
      begin
        state_r <= e_idle;
      end
    end
  end

  assign pf_v_o    = (state_r == e_emit);
  assign pf_addr_o = addr_r;

endmodule

// File: verilog/sched_pkg.sv
// shared widths, constants and packet types of the back-end scheduler
// addresses are Sv39 virtual addresses, data paths are 64 bits wide
package sched_pkg;

  localparam int vaddr_width_lp    = 39;
  localparam int dword_width_lp    = 64;
  localparam int reg_addr_width_lp = 5;
  localparam int instr_width_lp    = 32;
  localparam int stride_width_lp   = 8;
  localparam int num_regs_lp       = 32;

  // stride table is indexed by pc[3:2]
  localparam int stride_entries_lp   = 4;
  localparam int stride_idx_width_lp = $clog2(stride_entries_lp);

  localparam int prefetch_depth_lp = 4;
  localparam int pf_count_width_lp = $clog2(prefetch_depth_lp + 1);

  typedef logic [vaddr_width_lp-1:0]           vaddr_t;
  typedef logic [dword_width_lp-1:0]           dword_t;
  typedef logic [reg_addr_width_lp-1:0]        reg_addr_t;
  typedef logic [instr_width_lp-1:0]           instr_t;
  typedef logic signed [stride_width_lp-1:0]   stride_t;

  typedef enum logic [2:0]
  {
    e_none, e_instr, e_fe_exc, e_late_wb, e_resume, e_interrupt, e_prefetch
  } dispatch_kind_e;

  typedef enum logic {e_idle, e_emit} gen_state_e;

  typedef struct packed
  {
    vaddr_t pc;
    instr_t instr;
    logic   rs1_r_v;
    logic   rs2_r_v;
    dword_t imm;
    logic   load_v;
    // exception packet rather than an instruction
    logic   exc_v;
    logic   instr_page_fault;
    logic   illegal_instr;
    logic   ecall;
    logic   ebreak;
  } fe_pkt_s;

  typedef struct packed
  {
    logic      w_v;
    reg_addr_t rd_addr;
    dword_t    data;
  } wb_pkt_s;

  typedef struct packed
  {
    logic instr_page_fault;
    logic illegal_instr;
    logic ecall;
    logic ebreak;
    logic resume;
    logic interrupt;
  } exception_s;

  typedef struct packed
  {
    logic           v;
    dispatch_kind_e kind;
    vaddr_t         pc;
    instr_t         instr;
    dword_t         rs1;
    dword_t         rs2;
    dword_t         imm;
    reg_addr_t      rd_addr;
    exception_s     exception;
  } dispatch_pkt_s;

  typedef struct packed
  {
    vaddr_t  base;
    stride_t stride;
  } prefetch_req_s;

endpackage

// File: verilog/stride_detector.sv
// direct-mapped table of recent loads, indexed by pc[3:2], tagged by the full pc
// a request needs two equal nonzero strides in a row, so three loads from one pc
`timescale 1ns/10ps

module stride_detector
  (input logic                    clk_i
   , input logic                  reset_i

   , input logic                  load_v_i
   , input sched_pkg::vaddr_t     pc_i
   , input sched_pkg::vaddr_t     eff_addr_i

   , output logic                 pf_req_v_o
   , output sched_pkg::prefetch_req_s pf_req_o
   );

  import sched_pkg::*;

  logic [stride_entries_lp-1:0] valid_r;
  vaddr_t  tag_r       [stride_entries_lp];
  vaddr_t  last_addr_r [stride_entries_lp];
  stride_t stride_r    [stride_entries_lp];

  logic [stride_idx_width_lp-1:0] idx;
  vaddr_t        diff;
  stride_t       new_stride;
  logic          hit, fits, confirm;
  logic          pf_req_v_r;
  prefetch_req_s pf_req_r;

  assign idx = pc_i[stride_idx_width_lp+1:2];
  assign hit = valid_r[idx] & (tag_r[idx] == pc_i);

  assign diff       = eff_addr_i - last_addr_r[idx];
  assign new_stride = diff[stride_width_lp-1:0];

  // upper bits must be a pure sign extension of the stride
  assign fits = (diff[vaddr_width_lp-1:stride_width_lp-1] == '0)
              | (diff[vaddr_width_lp-1:stride_width_lp-1] == '1);

  assign confirm = load_v_i & hit & fits & (new_stride != '0)
                 & (new_stride == stride_r[idx]);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r    <= '0;
      pf_req_v_r <= 1'b0;
    end
    else
    begin
      pf_req_v_r <= confirm;
      if (load_v_i)
      begin
        valid_r[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (confirm)
    begin
      pf_req_r.base   <= eff_addr_i;
      pf_req_r.stride <= new_stride;
    end
    if (load_v_i)
    begin
      last_addr_r[idx] <= eff_addr_i;
      if (hit & fits)
      begin
        stride_r[idx] <= new_stride;
      end
      else
      begin
        // new pc, or a jump too large to track
        tag_r[idx]    <= pc_i;
        stride_r[idx] <= '0;
      end
    end
  end

  assign pf_req_v_o = pf_req_v_r;
  assign pf_req_o   = pf_req_r;

endmodule
